// File: build.f
src/amac_pkg.sv
src/approx_mult_16.sv
src/operand_stage.sv
src/product_stage.sv
src/accum_stage.sv
src/amac_top.sv
verif/amac_checker.sv
verif/amac_tb.sv

// File: src/accum_stage.sv
`timescale 1ns/100ps

module accum_stage #(
    parameter int ACC_W = 40
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       s2_valid,
    output logic                       s2_ready,
    input  amac_pkg::amac_prod_t       s2_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [ACC_W-1:0]           out_sum,
    output logic [amac_pkg::CNT_W-1:0] out_count
);

    import amac_pkg::*;

    logic [ACC_W-1:0] run_sum;
    logic [CNT_W-1:0] run_count;
    logic [ACC_W-1:0] sum_next;
    logic [CNT_W-1:0] count_next;
    logic             take;

    // Stall while a finished result still waits for the consumer
    assign s2_ready = ~out_valid | out_ready;
    assign take     = s2_valid & s2_ready;

    assign sum_next   = run_sum + ACC_W'(s2_data.prod);  // Sign extended, wraps at ACC_W
    assign count_next = run_count + CNT_W'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            run_sum   <= '0;
            run_count <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (take) begin
                if (s2_data.last) begin
                    // Frame closes, the next one starts from zero
                    run_sum   <= '0;
                    run_count <= '0;
                    out_valid <= 1'b1;
                end else begin
                    run_sum   <= sum_next;
                    run_count <= count_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && s2_data.last) begin
            out_sum   <= sum_next;
            out_count <= count_next;
        end
    end

endmodule

// File: src/amac_pkg.sv
package amac_pkg;

    localparam int OPND_W = 16;
    localparam int PROD_W = 32;
    localparam int CNT_W  = 8;   // Samples per frame wrap at 256

    // One operand pair as it travels from the input port to the multiplier
    typedef struct packed {
        logic signed [OPND_W-1:0] a;
        logic signed [OPND_W-1:0] b;
        logic                     exact;  // Take the true product for this sample
        logic                     last;   // Final sample of the frame
    } amac_sample_t;

    typedef struct packed {
        logic signed [PROD_W-1:0] prod;
        logic                     last;
    } amac_prod_t;

endpackage

// File: src/amac_top.sv
`timescale 1ns/100ps

module amac_top #(
    parameter int ACC_W = 40
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  amac_pkg::amac_sample_t     in_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [ACC_W-1:0]           out_sum,
    output logic [amac_pkg::CNT_W-1:0] out_count
);

    import amac_pkg::*;

    logic         s1_valid;
    logic         s1_ready;
    amac_sample_t s1_data;
    logic         s2_valid;
    logic         s2_ready;
    amac_prod_t   s2_data;

    operand_stage opnd0 (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_data),
        .s1_valid (s1_valid),
        .s1_ready (s1_ready),
        .s1_data  (s1_data)
    );

    product_stage prod0 (
        .clk      (clk),
        .rst      (rst),
        .s1_valid (s1_valid),
        .s1_ready (s1_ready),
        .s1_data  (s1_data),
        .s2_valid (s2_valid),
        .s2_ready (s2_ready),
        .s2_data  (s2_data)
    );

    accum_stage #(
        .ACC_W (ACC_W)
    ) acc0 (
        .clk       (clk),
        .rst       (rst),
        .s2_valid  (s2_valid),
        .s2_ready  (s2_ready),
        .s2_data   (s2_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_sum   (out_sum),
        .out_count (out_count)
    );

endmodule

// File: src/approx_mult_16.sv
`timescale 1ns/100ps

module approx_mult_16 (
    input  logic [15:0] x,
    input  logic [15:0] y,
    output logic [31:0] z
);

    // Row k holds the partial product for x[k], sign column already inverted
    logic [15:0] pp [16];

    // Sparse vectors left after compressing rows 0 to 5
    logic [20:0] cv1;
    logic [20:0] cv2;
    logic [20:0] cv3;
    logic [20:0] cv4;

    logic [31:0] upper_sum;

    always_comb begin
        for (int k = 0; k < 15; k++) begin
            pp[k][14:0] = y[14:0] & {15{x[k]}};
            pp[k][15]   = ~(y[15] & x[k]);
        end
        // The x sign row is the complement except at the sign-by-sign bit
        pp[15][14:0] = ~(y[14:0] & {15{x[15]}});
        pp[15][15]   = y[15] & x[15];
    end

    // First vector collects most of the AND and XOR compressor outputs
    always_comb begin
        cv1     = '0;
        cv1[0]  = pp[0][0];
        cv1[2]  = pp[0][1] & pp[1][0];
        cv1[3]  = pp[0][3] ^ pp[1][2];
        cv1[4]  = pp[0][4] ^ pp[1][3];
        cv1[5]  = pp[2][2] & pp[3][1];
        cv1[8]  = pp[4][4] ^ pp[5][3];
        cv1[9]  = pp[2][6] & pp[3][5];
        cv1[10] = pp[2][8] ^ pp[3][7];
        cv1[11] = pp[4][6] & pp[5][5];
        cv1[13] = pp[0][13] ^ pp[1][12];
        cv1[15] = pp[4][10] & pp[5][9];
        cv1[16] = pp[2][13] & pp[3][12];
        cv1[17] = pp[1][15];
        cv1[18] = pp[2][15] & pp[3][14];
        cv1[19] = pp[4][14] & pp[5][13];
        cv1[20] = pp[4][15] & pp[5][14];
    end

    always_comb begin
        cv2     = '0;
        cv2[2]  = pp[2][0];
        cv2[10] = pp[4][6] ^ pp[5][5];
        cv2[13] = pp[2][11] ^ pp[3][10];
        cv2[16] = pp[4][12] ^ pp[5][11];
        cv2[17] = 1'b1;                     // Folded correction one of the first row
        cv2[18] = pp[3][15];
        cv2[19] = pp[4][15] ^ pp[5][14];
        cv2[20] = pp[5][15];
    end

    // The last two vectors only carry a few bits near column 17
    always_comb begin
        cv3     = '0;
        cv3[17] = pp[2][15] ^ pp[3][14];
        cv3[18] = pp[4][14] ^ pp[5][13];
    end

    always_comb begin
        cv4     = '0;
        cv4[17] = pp[4][12] & pp[5][11];
    end

    // Rows 6 to 15 are summed exactly, the top correction one lands on bit 31
    always_comb begin
        upper_sum = {1'b1, pp[15], 15'b0};
        for (int k = 6; k < 15; k++) begin
            upper_sum = upper_sum + (32'(pp[k]) << k);
        end
    end

    assign z = upper_sum + 32'(cv1) + 32'(cv2) + 32'(cv3) + 32'(cv4);

endmodule

// File: src/operand_stage.sv
`timescale 1ns/100ps

module operand_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  amac_pkg::amac_sample_t in_data,
    output logic                   s1_valid,
    input  logic                   s1_ready,
    output amac_pkg::amac_sample_t s1_data
);

    logic take;

    // Free slot, or the held sample leaves on this same edge
    assign in_ready = ~s1_valid | s1_ready;
    assign take     = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (in_ready) begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            s1_data <= in_data;
        end
    end

endmodule

// File: src/product_stage.sv
`timescale 1ns/100ps

module product_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   s1_valid,
    output logic                   s1_ready,
    input  amac_pkg::amac_sample_t s1_data,
    output logic                   s2_valid,
    input  logic                   s2_ready,
    output amac_pkg::amac_prod_t   s2_data
);

    import amac_pkg::*;

    logic [PROD_W-1:0]          approx_z;
    logic signed [2*OPND_W-1:0] exact_z;
    amac_prod_t                 prod_next;
    logic                       take;

    approx_mult_16 mult0 (
        .x (s1_data.a),
        .y (s1_data.b),
        .z (approx_z)
    );

    assign exact_z = s1_data.a * s1_data.b;  // Both operands signed

    always_comb begin
        prod_next.prod = s1_data.exact ? exact_z : approx_z;
        prod_next.last = s1_data.last;
    end

    assign s1_ready = ~s2_valid | s2_ready;
    assign take     = s1_valid & s1_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (s1_ready) begin
            s2_valid <= s1_valid;
        end
    end

    // Only the selected product is kept, the other one is dropped here
    always_ff @(posedge clk) begin
        if (take) begin
            s2_data <= prod_next;
        end
    end

endmodule

// File: verif/amac_checker.sv
`timescale 1ns/100ps

module amac_checker #(
    parameter int ACC_W = 40
) (
    input logic                       clk,
    input logic                       rst,
    input logic                       in_valid,
    input logic                       in_ready,
    input amac_pkg::amac_sample_t     in_data,
    input logic                       out_valid,
    input logic                       out_ready,
    input logic [ACC_W-1:0]           out_sum,
    input logic [amac_pkg::CNT_W-1:0] out_count,
    input logic                       s1_valid,
    input logic                       s2_valid
);

    int fail_count = 0;

    // A stalled input sample must not change before it is taken
    assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else begin
            $error("Input sample changed while stalled");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_sum) && $stable(out_count))
        else begin
            $error("Frame result changed while stalled");
            fail_count++;
        end

    assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            $error("Result valid after a reset edge");
            fail_count++;
        end

    // Back-pressure reaches the input only when every stage is full and the result is stalled
    assert property (@(posedge clk) disable iff (rst)
        !in_ready |-> (s1_valid && s2_valid && out_valid && !out_ready))
        else begin
            $error("Input stalled while the pipeline could still move");
            fail_count++;
        end

endmodule

bind amac_top amac_checker #(.ACC_W(ACC_W)) chk0 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_sum   (out_sum),
    .out_count (out_count),
    .s1_valid  (s1_valid),
    .s2_valid  (s2_valid)
);

// File: verif/amac_tb.sv
`timescale 1ns/100ps

module amac_tb;

    import amac_pkg::*;

    localparam int ACC_W        = 40;
    localparam int ACCEPT_LIMIT = 200;
    localparam int RESULT_LIMIT = 2000;

    localparam int OP_PASS = 0;
    localparam int OP_AND  = 1;
    localparam int OP_XOR  = 2;
    localparam int OP_ONE  = 3;

    localparam int READY_ON   = 0;
    localparam int READY_RAND = 1;
    localparam int READY_LOW  = 2;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic             in_ready;
    amac_sample_t     in_data;
    logic             out_valid;
    logic             out_ready;
    logic [ACC_W-1:0] out_sum;
    logic [CNT_W-1:0] out_count;

    logic [31:0]      stim_seed = 32'd50594;
    logic [31:0]      bp_seed   = 32'd50594;  // Separate stream for the result port
    int               ready_mode = READY_ON;
    bit               lat_check = 1'b0;
    int               cycle = 0;

    amac_sample_t     stim_q[$];
    logic [ACC_W-1:0] exp_sum_q[$];
    logic [CNT_W-1:0] exp_cnt_q[$];
    int               acc_cycle_q[$];
    logic [ACC_W-1:0] model_sum;
    logic [CNT_W-1:0] model_cnt;

    string            cur_test = "init";
    int               errors = 0;
    int               checks = 0;
    int               tests_run = 0;
    int               tests_bad = 0;
    int               test_err0 = 0;
    int               results_seen = 0;

    amac_top #(
        .ACC_W (ACC_W)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_sum   (out_sum),
        .out_count (out_count)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(input string what, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            $display("Fail %s %s: expected %0h, actual %0h", cur_test, what, exp_v, act_v);
            errors++;
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_seed = lcg_next(stim_seed);
        return stim_seed;
    endfunction

    // A sign bit paired with a magnitude bit is inverted in Baugh-Wooley rows
    function automatic logic pp_bit(input logic [15:0] x, input logic [15:0] y,
                                    input int k, input int j);
        logic b;
        b = x[k] & y[j];
        if ((k == 15) != (j == 15)) begin
            b = ~b;
        end
        return b;
    endfunction

    function automatic logic [31:0] comp_term(input logic [15:0] x, input logic [15:0] y,
                                              input int op, input int pos,
                                              input int r1, input int c1,
                                              input int r2, input int c2);
        logic b;
        case (op)
            OP_PASS: b = pp_bit(x, y, r1, c1);
            OP_AND:  b = pp_bit(x, y, r1, c1) & pp_bit(x, y, r2, c2);
            OP_XOR:  b = pp_bit(x, y, r1, c1) ^ pp_bit(x, y, r2, c2);
            default: b = 1'b1;
        endcase
        return 32'(b) << pos;
    endfunction

    function automatic logic [31:0] approx_product(input logic [15:0] x, input logic [15:0] y);
        logic [31:0] acc;
        acc = 32'h8000_0000;  // Correction one of the last row
        for (int k = 6; k < 16; k++) begin
            for (int j = 0; j < 16; j++) begin
                acc += 32'(pp_bit(x, y, k, j)) << (k + j);
            end
        end
        // Rows 0 to 5 after the approximate compressors
        acc += comp_term(x, y, OP_PASS, 0, 0, 0, 0, 0);
        acc += comp_term(x, y, OP_AND, 2, 0, 1, 1, 0);
        acc += comp_term(x, y, OP_PASS, 2, 2, 0, 0, 0);
        acc += comp_term(x, y, OP_XOR, 3, 0, 3, 1, 2);
        acc += comp_term(x, y, OP_XOR, 4, 0, 4, 1, 3);
        acc += comp_term(x, y, OP_AND, 5, 2, 2, 3, 1);
        acc += comp_term(x, y, OP_XOR, 8, 4, 4, 5, 3);
        acc += comp_term(x, y, OP_AND, 9, 2, 6, 3, 5);
        acc += comp_term(x, y, OP_XOR, 10, 2, 8, 3, 7);
        acc += comp_term(x, y, OP_XOR, 10, 4, 6, 5, 5);
        acc += comp_term(x, y, OP_AND, 11, 4, 6, 5, 5);
        acc += comp_term(x, y, OP_XOR, 13, 0, 13, 1, 12);
        acc += comp_term(x, y, OP_XOR, 13, 2, 11, 3, 10);
        acc += comp_term(x, y, OP_AND, 15, 4, 10, 5, 9);
        acc += comp_term(x, y, OP_AND, 16, 2, 13, 3, 12);
        acc += comp_term(x, y, OP_XOR, 16, 4, 12, 5, 11);
        acc += comp_term(x, y, OP_PASS, 17, 1, 15, 0, 0);
        acc += comp_term(x, y, OP_ONE, 17, 0, 0, 0, 0);   // First row correction one
        acc += comp_term(x, y, OP_XOR, 17, 2, 15, 3, 14);
        acc += comp_term(x, y, OP_AND, 17, 4, 12, 5, 11);
        acc += comp_term(x, y, OP_AND, 18, 2, 15, 3, 14);
        acc += comp_term(x, y, OP_PASS, 18, 3, 15, 0, 0);
        acc += comp_term(x, y, OP_XOR, 18, 4, 14, 5, 13);
        acc += comp_term(x, y, OP_AND, 19, 4, 14, 5, 13);
        acc += comp_term(x, y, OP_XOR, 19, 4, 15, 5, 14);
        acc += comp_term(x, y, OP_AND, 20, 4, 15, 5, 14);
        acc += comp_term(x, y, OP_PASS, 20, 5, 15, 0, 0);
        return acc;
    endfunction

    function automatic logic signed [31:0] model_product(input amac_sample_t s);
        logic signed [31:0] p;
        if (s.exact) begin
            p = s.a * s.b;
        end else begin
            p = approx_product(s.a, s.b);
        end
        return p;
    endfunction

    // Queue one sample and fold it into the frame model
    task automatic push_sample(input amac_sample_t s);
        logic signed [ACC_W-1:0] ext;
        ext = model_product(s);
        stim_q.push_back(s);
        model_sum = model_sum + ext;
        model_cnt = model_cnt + 1'b1;
        if (s.last) begin
            exp_sum_q.push_back(model_sum);
            exp_cnt_q.push_back(model_cnt);
            model_sum = '0;
            model_cnt = '0;
        end
    endtask

    // Mode 0 exact, 1 approximate, 2 mixed per sample
    task automatic add_frame(input int len, input int mode, input bit close);
        amac_sample_t s;
        logic [31:0]  r;
        for (int i = 0; i < len; i++) begin
            r = next_rand();
            s.a = r[31:16];
            r = next_rand();
            s.b = r[31:16];
            s.exact = (mode == 2) ? r[15] : (mode == 0);
            s.last = close && (i == len - 1);
            push_sample(s);
        end
    endtask

    function automatic int rand_len();
        logic [31:0] r;
        r = next_rand();
        return 1 + int'(r[31:16] % 20);
    endfunction

    task automatic model_clear();
        model_sum = '0;
        model_cnt = '0;
        exp_sum_q.delete();
        exp_cnt_q.delete();
        acc_cycle_q.delete();
    endtask

    task automatic drive_samples(input bit gaps);
        int          waited;
        logic [31:0] r;
        while (stim_q.size() > 0) begin
            if (gaps) begin
                r = next_rand();
                if (r[31:30] == 2'b00) begin
                    in_valid <= 1'b0;
                    @(posedge clk);
                end
            end
            in_valid <= 1'b1;
            in_data  <= stim_q.pop_front();
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!in_ready && waited < ACCEPT_LIMIT);
            if (!in_ready) begin
                $display("Error: %s, input sample not accepted within %0d cycles",
                         cur_test, ACCEPT_LIMIT);
                errors++;
                stim_q.delete();
            end else if (lat_check) begin
                acc_cycle_q.push_back(cycle);
                check_value("accept wait", 1, waited);
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic wait_results();
        int n;
        n = 0;
        while (exp_sum_q.size() > 0 && n < RESULT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_sum_q.size() > 0) begin
            $display("Error: %s, %0d frame results never arrived", cur_test, exp_sum_q.size());
            errors++;
            model_clear();
        end
    endtask

    task automatic apply_reset(input int cycles);
        rst      <= 1'b1;
        in_valid <= 1'b0;
        repeat (cycles) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors != test_err0) begin
            tests_bad++;
        end
        $display("Test %s finished with %0d errors", cur_test, errors - test_err0);
    endtask

    always @(posedge clk) begin
        bp_seed = lcg_next(bp_seed);
        case (ready_mode)
            READY_ON:   out_ready <= 1'b1;
            READY_RAND: out_ready <= (bp_seed[31:30] != 2'b00);
            default:    out_ready <= 1'b0;
        endcase
    end

    // Frames come back in the order they were sent
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            results_seen++;
            if (exp_sum_q.size() == 0) begin
                $display("Error: %s, result with sum %0h arrived with no frame outstanding",
                         cur_test, out_sum);
                errors++;
            end else begin
                check_value("sum", exp_sum_q.pop_front(), out_sum);
                check_value("count", exp_cnt_q.pop_front(), out_count);
                if (lat_check && acc_cycle_q.size() > 0) begin
                    check_value("latency", 3, cycle - acc_cycle_q.pop_front());
                end
            end
        end
    end

    initial begin
        logic [15:0]  corners [5];
        amac_sample_t s;
        int           seen0;
        int           n;
        corners = '{16'h8000, 16'h0000, 16'h0001, 16'hFFFF, 16'h7FFF};
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        model_clear();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        start_test("exact_frames");
        for (int f = 0; f < 6; f++) add_frame(rand_len(), 0, 1'b1);
        drive_samples(1'b1);
        wait_results();
        end_test();

        start_test("approx_frames");
        for (int f = 0; f < 6; f++) add_frame(rand_len(), 1, 1'b1);
        foreach (corners[i]) begin
            foreach (corners[j]) begin
                s = '{a: corners[i], b: corners[j], exact: 1'b0, last: 1'b1};
                push_sample(s);
            end
        end
        drive_samples(1'b0);
        wait_results();
        end_test();

        start_test("mixed_frames");
        for (int f = 0; f < 8; f++) add_frame(rand_len(), 2, 1'b1);
        drive_samples(1'b1);
        wait_results();
        end_test();

        start_test("backpressure");
        ready_mode <= READY_RAND;
        seen0 = results_seen;
        for (int f = 0; f < 12; f++) add_frame(rand_len(), 2, 1'b1);
        drive_samples(1'b1);
        wait_results();
        check_value("result count", 12, results_seen - seen0);
        ready_mode <= READY_ON;
        end_test();

        start_test("throughput");
        lat_check <= 1'b1;
        repeat (2) @(posedge clk);
        for (int f = 0; f < 16; f++) add_frame(1, 2, 1'b1);
        drive_samples(1'b0);
        wait_results();
        lat_check <= 1'b0;
        end_test();

        start_test("midrun_reset");
        ready_mode <= READY_LOW;
        add_frame(3, 0, 1'b1);
        add_frame(2, 2, 1'b0);  // Partial frame left in the pipe
        drive_samples(1'b0);
        n = 0;
        while (!out_valid && n < ACCEPT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        check_value("pending before reset", 1, out_valid);
        model_clear();
        apply_reset(3);
        check_value("out_valid after reset", 0, out_valid);
        ready_mode <= READY_ON;
        add_frame(4, 2, 1'b0);  // This partial frame reaches the running sum
        drive_samples(1'b0);
        repeat (3) @(posedge clk);
        model_clear();
        apply_reset(3);
        add_frame(5, 2, 1'b1);
        drive_samples(1'b0);
        wait_results();
        end_test();

        if (dut0.chk0.fail_count != 0) begin
            $display("Error: %0d assertion failures in the bound checker",
                     dut0.chk0.fail_count);
            errors++;
        end
        $display("Tests run: %0d, tests with errors: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
